// ==== filelist.f ====
+incdir+hdl
hdl/axi_wr_pkg.sv
hdl/mem_wr_front.sv
hdl/wr_req_fifo.sv
hdl/axi_wr_engine.sv
hdl/mem_axi4_wr_bridge.sv
verif/tb_mem_axi4_wr_bridge.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the write bridge testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f filelist.f \
    --top-module tb_mem_axi4_wr_bridge \
    --Mdir obj_dir

output="$(./obj_dir/Vtb_mem_axi4_wr_bridge)"
echo "$output"

if grep -q "SIMULATION PASSED" <<< "$output"; then
    exit 0
else
    exit 1
fi

// ==== verif/tb_mem_axi4_wr_bridge.sv ====
// Testbench for the memory-to-AXI4 write bridge
// Drives request and data strobes, models an AXI4 write slave with random
// ready stalls and checks every AW and W handshake against a scoreboard.

`include "axi_wr_consts.svh"

module tb_mem_axi4_wr_bridge;

    // 1 + 11 + 260 + 2 + 14 + 2 beats over all tests
    localparam int TOTAL_BEATS = 290;
    localparam int CYCLE_LIMIT = TOTAL_BEATS * 8 + 500;

    logic        clk_i;
    logic        reset_n_i;
    logic        mem_req_i;
    logic        mem_en_i;
    logic [31:0] mem_addr_i;
    logic [3:0]  mem_wben_i;
    logic [31:0] mem_wdata_i;
    logic        mem_wstall_o;
    logic        mem_wdata_infifo_o;
    logic [31:0] mem_axi4_error_o;
    logic        aw_ready;
    logic        aw_valid;
    logic [31:0] aw_addr;
    logic [7:0]  aw_len;
    logic [2:0]  aw_size;
    logic [1:0]  aw_burst;
    logic        w_ready;
    logic        w_valid;
    logic [31:0] w_data;
    logic [3:0]  w_strb;
    logic        w_last;
    logic        b_valid;
    logic [1:0]  b_resp;
    logic        b_ready;

    // scoreboard holds {addr, len} per AW and {data, strb, last} per W
    logic [39:0] exp_aw[$];
    logic [36:0] exp_w[$];
    int          b_pend;
    int          req_left;
    int          burst_left;
    int          ready_mode;
    logic [1:0]  resp_code;
    logic [31:0] lfsr;
    int          cycle_count;
    int          error_count;
    int          test_errors;
    int          tests_run;
    int          tests_failed;
    string       cur_test;
    bit          saw_stall;

    mem_axi4_wr_bridge u_dut (
        .clk_i              (clk_i),
        .reset_n_i          (reset_n_i),
        .mem_req_i          (mem_req_i),
        .mem_en_i           (mem_en_i),
        .mem_addr_i         (mem_addr_i),
        .mem_wben_i         (mem_wben_i),
        .mem_wdata_i        (mem_wdata_i),
        .mem_wstall_o       (mem_wstall_o),
        .mem_wdata_infifo_o (mem_wdata_infifo_o),
        .mem_axi4_error_o   (mem_axi4_error_o),
        .axi4_aw_ready_i    (aw_ready),
        .axi4_aw_valid_o    (aw_valid),
        .axi4_aw_addr_o     (aw_addr),
        .axi4_aw_len_o      (aw_len),
        .axi4_aw_size_o     (aw_size),
        .axi4_aw_burst_o    (aw_burst),
        .axi4_w_ready_i     (w_ready),
        .axi4_w_valid_o     (w_valid),
        .axi4_w_data_o      (w_data),
        .axi4_w_strb_o      (w_strb),
        .axi4_w_last_o      (w_last),
        .axi4_b_valid_i     (b_valid),
        .axi4_b_resp_i      (b_resp),
        .axi4_b_ready_o     (b_ready)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // beats per request are bytes / 4 plus one for any offset and one more on spill
    function automatic int beats_for(input logic [31:0] addr, input logic [31:0] len);
        int n;
        int extra;
        n = int'(len >> 2);
        extra = int'(len[1:0]) + int'(addr[1:0]);
        if (extra != 0) n++;
        if (extra > 4) n++;
        return n;
    endfunction

    task automatic check_value(input string what, input logic [63:0] exp, input logic [63:0] act);
        assert (exp == act) else begin
            $display("Mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
            error_count++;
        end
    endtask

    task automatic check_true(input bit cond, input string msg);
        assert (cond) else begin
            $display("%s: %s", cur_test, msg);
            error_count++;
        end
    endtask

    // ------------------------------------------------------------------------
    // AXI slave model driven on the falling edge
    // ------------------------------------------------------------------------
    always @(negedge clk_i) begin
        if (!reset_n_i) begin
            aw_ready = 1'b0;
            w_ready  = 1'b0;
            b_valid  = 1'b0;
        end else begin
            if (ready_mode == 0) begin
                aw_ready = 1'b1;
                w_ready  = 1'b1;
            end else if (ready_mode == 1) begin
                aw_ready = lfsr[0];
                lfsr     = lfsr_next(lfsr);
                w_ready  = lfsr[0];
                lfsr     = lfsr_next(lfsr);
            end else begin
                aw_ready = 1'b0;
                w_ready  = 1'b0;
            end
            b_valid = (b_pend != 0);
            b_resp  = resp_code;
        end
    end

    // handshake monitor
    always @(posedge clk_i) begin
        if (reset_n_i) begin
            if (exp_aw.size() != 0 || exp_w.size() != 0 || b_pend != 0) begin
                check_true(mem_wdata_infifo_o, "pending flag low while writes outstanding");
            end
            if (aw_valid && aw_ready) begin
                if (exp_aw.size() == 0) begin
                    check_true(1'b0, "AW handshake with no burst expected");
                end else begin
                    check_value("aw", 64'(exp_aw.pop_front()), 64'({aw_addr, aw_len}));
                    check_value("aw_size", 64'(`LOG_DATA_BYTES), 64'(aw_size));
                    check_value("aw_burst", 64'(1), 64'(aw_burst));
                end
            end
            if (w_valid && w_ready) begin
                if (exp_w.size() == 0) begin
                    check_true(1'b0, "W handshake with no beat expected");
                end else begin
                    check_value("w", 64'(exp_w.pop_front()), 64'({w_data, w_strb, w_last}));
                end
                if (w_last) b_pend++;
            end
            if (b_valid && b_ready) b_pend--;
        end
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // memory-side stimulus
    // ------------------------------------------------------------------------
    task automatic strobe(input bit req, input logic [31:0] addr, input logic [3:0] wben,
                          input logic [31:0] data);
        while (mem_wstall_o) @(negedge clk_i);
        mem_req_i   = req;
        mem_en_i    = !req;
        mem_addr_i  = addr;
        mem_wben_i  = wben;
        mem_wdata_i = data;
        @(negedge clk_i);
        mem_req_i  = 1'b0;
        mem_en_i   = 1'b0;
        mem_wben_i = 4'h0;
    endtask

    task automatic send_req(input logic [31:0] addr, input logic [31:0] len);
        int n;
        int k;
        int chunk;
        n = beats_for(addr, len);
        strobe(1'b1, addr, 4'hf, len);
        k = 0;
        while (k * 256 < n) begin
            chunk = (n - k * 256 > 256) ? 256 : n - k * 256;
            exp_aw.push_back({addr + 32'(k * 1024), 8'(chunk - 1)});
            k++;
        end
        req_left   = n;
        burst_left = (n > 256) ? 256 : n;
        // the staged entry reaches the FIFO before the next stall check
        @(negedge clk_i);
    endtask

    task automatic send_beat(input logic [31:0] addr, input logic [3:0] wben,
                             input logic [31:0] data);
        strobe(1'b0, addr, wben, data);
        if (req_left > 0) begin
            exp_w.push_back({data, wben, burst_left == 1});
            req_left--;
            burst_left--;
            if (burst_left == 0) burst_left = (req_left > 256) ? 256 : req_left;
        end else begin
            exp_aw.push_back({addr, 8'd0});
            exp_w.push_back({data, wben, 1'b1});
        end
        @(negedge clk_i);
    endtask

    task automatic wait_idle();
        while (exp_aw.size() != 0 || exp_w.size() != 0 || b_pend != 0) @(negedge clk_i);
        repeat (3) @(negedge clk_i);
        check_true(!mem_wdata_infifo_o, "pending flag still high after the final response");
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = error_count;
        tests_run++;
    endtask

    task automatic end_test();
        if (error_count == test_errors) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: failed with %0d errors", cur_test, error_count - test_errors);
            tests_failed++;
        end
    endtask

    initial begin
        logic [31:0] err_before;
        reset_n_i = 1'b0;
        mem_req_i = 1'b0;
        mem_en_i = 1'b0;
        mem_addr_i = '0;
        mem_wben_i = '0;
        mem_wdata_i = '0;
        aw_ready = 1'b0;
        w_ready = 1'b0;
        b_valid = 1'b0;
        b_resp = 2'b00;
        resp_code = 2'b00;
        lfsr = 32'ha0ca;
        ready_mode = 0;
        b_pend = 0;
        req_left = 0;
        burst_left = 0;
        cycle_count = 0;
        error_count = 0;
        tests_run = 0;
        tests_failed = 0;
        cur_test = "reset";
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        reset_n_i = 1'b1;
        @(negedge clk_i);
        check_true(!mem_wdata_infifo_o, "pending flag high after reset");
        check_true(!aw_valid && !w_valid && !b_ready, "AXI valid or ready high after reset");
        check_value("error count after reset", 64'd0, 64'(mem_axi4_error_o));

        start_test("single_write");
        send_beat(32'h1000_0040, 4'h3, 32'hcafe_0001);
        wait_idle();
        end_test();

        start_test("burst_length");
        send_req(32'h0000_2002, 32'd40);
        for (int i = 0; i < 11; i++) send_beat(32'h0, 4'hf, 32'hb000_0000 + i);
        wait_idle();
        end_test();

        start_test("split");
        ready_mode = 1;
        send_req(32'h0001_0000, 32'd1040);
        for (int i = 0; i < 260; i++) send_beat(32'h0, 4'hf, 32'h5100_0000 ^ (i * 32'h0001_0101));
        wait_idle();
        end_test();

        start_test("error_count");
        ready_mode = 0;
        err_before = mem_axi4_error_o;
        resp_code  = 2'b10;
        send_beat(32'h3000_0000, 4'hf, 32'h0bad_0bad);
        wait_idle();
        check_value("error count", 64'(err_before + 1), 64'(mem_axi4_error_o));
        resp_code = 2'b00;
        send_beat(32'h3000_0004, 4'hf, 32'h600d_600d);
        wait_idle();
        check_value("error count", 64'(err_before + 1), 64'(mem_axi4_error_o));
        end_test();

        start_test("backpressure");
        ready_mode = 2;
        saw_stall  = 1'b0;
        for (int i = 0; i < 8; i++) send_beat(32'h4000_0000 + i * 4, 4'hf, 32'he000_0000 + i);
        for (int i = 0; i < 10 && !saw_stall; i++) begin
            saw_stall = mem_wstall_o;
            @(negedge clk_i);
        end
        check_true(saw_stall, "stall never rose with eight entries queued");
        ready_mode = 1;
        send_req(32'h0000_5000, 32'd16);
        for (int i = 0; i < 4; i++) send_beat(32'h0, 4'hf, 32'h7700_0000 + i);
        send_beat(32'h4000_0100, 4'h1, 32'h0000_00aa);
        send_beat(32'h4000_0104, 4'hc, 32'hbb00_0000);
        wait_idle();
        end_test();

        start_test("pending_flag");
        ready_mode = 0;
        send_req(32'h0000_6000, 32'd8);
        check_true(mem_wdata_infifo_o, "pending flag low after request strobe");
        send_beat(32'h0, 4'hf, 32'h1111_2222);
        send_beat(32'h0, 4'hf, 32'h3333_4444);
        wait_idle();
        end_test();

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// ==== hdl/mem_axi4_wr_bridge.sv ====
// Memory-to-AXI4 write bridge, top level
// Front end, write FIFO and burst engine in a chain; the AXI4 write
// channels leave on flat ports.

`include "axi_wr_consts.svh"

module mem_axi4_wr_bridge (
    input  logic                        clk_i,
    input  logic                        reset_n_i,

    // memory side
    input  logic                        mem_req_i,
    input  logic                        mem_en_i,
    input  logic [`AXI_ADDR_WIDTH-1:0]  mem_addr_i,
    input  logic [`AXI_STRB_WIDTH-1:0]  mem_wben_i,
    input  logic [`AXI_DATA_WIDTH-1:0]  mem_wdata_i,
    output logic                        mem_wstall_o,
    output logic                        mem_wdata_infifo_o,
    output logic [31:0]                 mem_axi4_error_o,

    // AXI4 write master
    input  logic                        axi4_aw_ready_i,
    output logic                        axi4_aw_valid_o,
    output logic [`AXI_ADDR_WIDTH-1:0]  axi4_aw_addr_o,
    output logic [7:0]                  axi4_aw_len_o,
    output logic [2:0]                  axi4_aw_size_o,
    output logic [1:0]                  axi4_aw_burst_o,
    input  logic                        axi4_w_ready_i,
    output logic                        axi4_w_valid_o,
    output logic [`AXI_DATA_WIDTH-1:0]  axi4_w_data_o,
    output logic [`AXI_STRB_WIDTH-1:0]  axi4_w_strb_o,
    output logic                        axi4_w_last_o,
    input  logic                        axi4_b_valid_i,
    input  logic [1:0]                  axi4_b_resp_i,
    output logic                        axi4_b_ready_o
);

    import axi_wr_pkg::*;

    logic      push;
    logic      staged;
    wr_entry_t entry;
    wr_entry_t head;
    logic      fifo_full;
    logic      fifo_empty;
    logic      pop;
    axi_aw_t   aw;
    axi_w_t    w;

    mem_wr_front u_front (
        .clk_i       (clk_i),
        .reset_n_i   (reset_n_i),
        .mem_req_i   (mem_req_i),
        .mem_en_i    (mem_en_i),
        .mem_addr_i  (mem_addr_i),
        .mem_wben_i  (mem_wben_i),
        .mem_wdata_i (mem_wdata_i),
        .push_o      (push),
        .entry_o     (entry),
        .staged_o    (staged)
    );

    wr_req_fifo u_fifo (
        .clk_i     (clk_i),
        .reset_n_i (reset_n_i),
        .push_i    (push),
        .entry_i   (entry),
        .pop_i     (pop),
        .head_o    (head),
        .full_o    (fifo_full),
        .empty_o   (fifo_empty)
    );

    axi_wr_engine u_engine (
        .clk_i          (clk_i),
        .reset_n_i      (reset_n_i),
        .head_i         (head),
        .empty_i        (fifo_empty),
        .staged_i       (staged),
        .aw_ready_i     (axi4_aw_ready_i),
        .w_ready_i      (axi4_w_ready_i),
        .b_valid_i      (axi4_b_valid_i),
        .b_resp_i       (axi4_b_resp_i),
        .pop_o          (pop),
        .aw_valid_o     (axi4_aw_valid_o),
        .aw_o           (aw),
        .w_valid_o      (axi4_w_valid_o),
        .w_o            (w),
        .b_ready_o      (axi4_b_ready_o),
        .error_count_o  (mem_axi4_error_o),
        .wdata_infifo_o (mem_wdata_infifo_o)
    );

    // master holds off while the FIFO is full
    assign mem_wstall_o = fifo_full;

    assign axi4_aw_addr_o  = aw.addr;
    assign axi4_aw_len_o   = aw.len;
    assign axi4_aw_size_o  = aw.size;
    assign axi4_aw_burst_o = aw.burst;
    assign axi4_w_data_o   = w.data;
    assign axi4_w_strb_o   = w.strb;
    assign axi4_w_last_o   = w.last;

endmodule

// ==== hdl/axi_wr_engine.sv ====
// AXI4 write burst engine
// Pulls requests and data beats from the write FIFO, issues AW and W,
// splits long requests into bursts of at most 256 beats, sends single
// writes for stray beats, collects B and counts error responses.

`include "axi_wr_consts.svh"

module axi_wr_engine (
    input  logic                  clk_i,
    input  logic                  reset_n_i,
    input  axi_wr_pkg::wr_entry_t head_i,
    input  logic                  empty_i,
    input  logic                  staged_i,
    input  logic                  aw_ready_i,
    input  logic                  w_ready_i,
    input  logic                  b_valid_i,
    input  logic [1:0]            b_resp_i,
    output logic                  pop_o,
    output logic                  aw_valid_o,
    output axi_wr_pkg::axi_aw_t   aw_o,
    output logic                  w_valid_o,
    output axi_wr_pkg::axi_w_t    w_o,
    output logic                  b_ready_o,
    output logic [31:0]           error_count_o,
    output logic                  wdata_infifo_o
);

    import axi_wr_pkg::*;

    localparam int CNT_W = `BEAT_COUNT_WIDTH;
    localparam logic [`AXI_ADDR_WIDTH-1:0] BURST_BYTES = `AXI_MAX_BEATS << `LOG_DATA_BYTES;

    typedef enum logic [2:0] {
        S_IDLE,
        S_WRITE_WAIT,
        S_BURST,
        S_WAIT_B,
        S_ERROR,
        S_FINISH
    } state_t;

    state_t                     state_q;
    state_t                     state_d;
    logic [CNT_W-1:0]           remain_q;
    logic [CNT_W-1:0]           remain_d;
    logic [8:0]                 burst_cnt_q;
    logic [8:0]                 burst_cnt_d;
    logic [`AXI_ADDR_WIDTH-1:0] next_addr_q;
    logic [`AXI_ADDR_WIDTH-1:0] next_addr_d;
    logic [31:0]                error_q;
    logic [31:0]                error_d;

    logic                       issue_burst;
    logic [`AXI_ADDR_WIDTH-1:0] burst_addr;
    logic [CNT_W-1:0]           src_count;
    logic [8:0]                 burst_beats;
    logic [8:0]                 len_full;
    logic                       head_beat;

    // ------------------------------------------------------------------------
    // next burst: leftover beats go first, then a new request
    // ------------------------------------------------------------------------
    assign head_beat   = !empty_i && !head_i.is_req;
    assign issue_burst = (remain_q != '0) || (!empty_i && head_i.is_req);
    assign burst_addr  = (remain_q != '0) ? next_addr_q : head_i.word.req.addr;
    assign src_count   = (remain_q != '0) ? remain_q : head_i.word.req.count;
    assign burst_beats = (src_count > `AXI_MAX_BEATS) ? 9'd256 : src_count[8:0];
    assign len_full    = burst_beats - 9'd1;

    always_comb begin
        state_d     = state_q;
        remain_d    = remain_q;
        burst_cnt_d = burst_cnt_q;
        next_addr_d = next_addr_q;
        error_d     = error_q;

        pop_o      = 1'b0;
        aw_valid_o = 1'b0;
        aw_o.addr  = burst_addr;
        aw_o.len   = len_full[7:0];
        aw_o.size  = 3'(`LOG_DATA_BYTES);
        aw_o.burst = `AXI_BURST_INCR;
        w_valid_o  = 1'b0;
        w_o.data   = head_i.word.beat.data;
        w_o.strb   = head_i.word.beat.strb;
        w_o.last   = 1'b0;
        b_ready_o  = 1'b0;

        case (state_q)
            S_IDLE: begin
                if (issue_burst) begin
                    aw_valid_o = 1'b1;
                    if (aw_ready_i) begin
                        // a request word leaves the FIFO once its first AW is taken
                        pop_o       = (remain_q == '0);
                        remain_d    = src_count - {{(CNT_W-9){1'b0}}, burst_beats};
                        burst_cnt_d = burst_beats;
                        next_addr_d = burst_addr + BURST_BYTES;
                        state_d     = S_BURST;
                    end
                end else if (head_beat) begin
                    // single write at the beat's own address
                    aw_valid_o = 1'b1;
                    aw_o.addr  = head_i.word.beat.addr;
                    aw_o.len   = 8'd0;
                    if (aw_ready_i) begin
                        w_valid_o = 1'b1;
                        w_o.last  = 1'b1;
                        if (w_ready_i) begin
                            pop_o   = 1'b1;
                            state_d = S_WAIT_B;
                        end else begin
                            state_d = S_WRITE_WAIT;
                        end
                    end
                end
            end

            S_WRITE_WAIT: begin
                w_valid_o = 1'b1;
                w_o.last  = 1'b1;
                if (w_ready_i) begin
                    pop_o   = 1'b1;
                    state_d = S_WAIT_B;
                end
            end

            S_BURST: begin
                if (head_beat) begin
                    w_valid_o = 1'b1;
                    w_o.last  = (burst_cnt_q == 9'd1);
                    if (w_ready_i) begin
                        pop_o       = 1'b1;
                        burst_cnt_d = burst_cnt_q - 9'd1;
                        if (burst_cnt_q == 9'd1) begin
                            state_d = S_WAIT_B;
                        end
                    end
                end
            end

            S_WAIT_B: begin
                b_ready_o = 1'b1;
                if (b_valid_i) begin
                    state_d = (b_resp_i == `AXI_RESP_OKAY) ? S_FINISH : S_ERROR;
                end
            end

            S_ERROR: begin
                error_d = error_q + 32'd1;
                state_d = S_FINISH;
            end

            S_FINISH: begin
                state_d = S_IDLE;
            end

            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    // ------------------------------------------------------------------------
    // state registers
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            state_q     <= S_IDLE;
            remain_q    <= '0;
            burst_cnt_q <= '0;
            error_q     <= '0;
        end else begin
            state_q     <= state_d;
            remain_q    <= remain_d;
            burst_cnt_q <= burst_cnt_d;
            error_q     <= error_d;
        end
    end

    always_ff @(posedge clk_i) begin
        next_addr_q <= next_addr_d;
    end

    assign error_count_o = error_q;

    // something is still on its way to the slave
    assign wdata_infifo_o = staged_i || !empty_i || (remain_q != '0)
                         || (state_q == S_BURST) || (state_q == S_WRITE_WAIT)
                         || (state_q == S_WAIT_B);

endmodule

// ==== hdl/wr_req_fifo.sv ====
// Write request FIFO
// Circular buffer of request and data entries between the memory front
// end and the burst engine, with full and empty flags.

`include "axi_wr_consts.svh"

module wr_req_fifo (
    input  logic                  clk_i,
    input  logic                  reset_n_i,
    input  logic                  push_i,
    input  axi_wr_pkg::wr_entry_t entry_i,
    input  logic                  pop_i,
    output axi_wr_pkg::wr_entry_t head_o,
    output logic                  full_o,
    output logic                  empty_o
);

    import axi_wr_pkg::*;

    localparam int PTR_W = `WR_FIFO_DEPTH_LOG;
    localparam int DEPTH = 1 << PTR_W;

    wr_entry_t        mem_q [DEPTH];
    logic [PTR_W-1:0] wr_ptr_q;
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W:0]   count_q;
    logic             do_push;
    logic             do_pop;

    // a push into a full buffer is dropped
    assign do_push = push_i && !full_o;
    assign do_pop  = pop_i && !empty_o;

    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (do_pop) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            if (do_push && !do_pop) begin
                count_q <= count_q + 1'b1;
            end else if (do_pop && !do_push) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= entry_i;
        end
    end

    assign head_o  = mem_q[rd_ptr_q];
    assign full_o  = (count_q == DEPTH);
    assign empty_o = (count_q == '0);

endmodule

// ==== hdl/mem_wr_front.sv ====
// Memory-side front end of the write bridge
// Classifies request and data strobes, turns a request's byte length into
// an AXI beat count and registers one FIFO entry per cycle.

`include "axi_wr_consts.svh"

module mem_wr_front (
    input  logic                        clk_i,
    input  logic                        reset_n_i,
    input  logic                        mem_req_i,
    input  logic                        mem_en_i,
    input  logic [`AXI_ADDR_WIDTH-1:0]  mem_addr_i,
    input  logic [`AXI_STRB_WIDTH-1:0]  mem_wben_i,
    input  logic [`AXI_DATA_WIDTH-1:0]  mem_wdata_i,
    output logic                        push_o,
    output axi_wr_pkg::wr_entry_t       entry_o,
    output logic                        staged_o
);

    import axi_wr_pkg::*;

    localparam int DATA_BYTES = `AXI_STRB_WIDTH;

    logic                         is_req;
    logic                         is_beat;
    logic [`LOG_DATA_BYTES:0]     extra;
    logic [`BEAT_COUNT_WIDTH-1:0] beat_count;
    wr_entry_t                    entry_d;
    logic                         push_q;

    // zero byte enables mark an idle cycle
    assign is_req  = mem_req_i && (|mem_wben_i);
    assign is_beat = mem_en_i && !mem_req_i && (|mem_wben_i);

    // one beat more for an unaligned start or length, another when the
    // two offsets together spill past a beat
    assign extra = {1'b0, mem_wdata_i[`LOG_DATA_BYTES-1:0]}
                 + {1'b0, mem_addr_i[`LOG_DATA_BYTES-1:0]};

    always_comb begin
        beat_count = mem_wdata_i[31:`LOG_DATA_BYTES];
        if (extra != '0) begin
            beat_count = beat_count + 1'b1;
        end
        if (extra > DATA_BYTES) begin
            beat_count = beat_count + 1'b1;
        end
    end

    always_comb begin
        entry_d.is_req = is_req;
        if (is_req) begin
            entry_d.word.req.pad   = '0;
            entry_d.word.req.addr  = mem_addr_i;
            entry_d.word.req.count = beat_count;
        end else begin
            entry_d.word.beat.addr = mem_addr_i;
            entry_d.word.beat.strb = mem_wben_i;
            entry_d.word.beat.data = mem_wdata_i;
        end
    end

    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            push_q <= 1'b0;
        end else begin
            push_q <= is_req || is_beat;
        end
    end

    always_ff @(posedge clk_i) begin
        entry_o <= entry_d;
    end

    assign push_o   = push_q;
    assign staged_o = push_q;

endmodule

// ==== hdl/axi_wr_pkg.sv ====
// Memory-to-AXI4 write bridge types
// FIFO entry layout and the AXI4 write channel payloads

`include "axi_wr_consts.svh"

package axi_wr_pkg;

    // request view of a FIFO word
    typedef struct packed {
        logic [`AXI_STRB_WIDTH+`AXI_DATA_WIDTH-`BEAT_COUNT_WIDTH-1:0] pad;
        logic [`AXI_ADDR_WIDTH-1:0]   addr;
        logic [`BEAT_COUNT_WIDTH-1:0] count;
    } wr_req_t;

    // data view, the address is kept for single writes
    typedef struct packed {
        logic [`AXI_ADDR_WIDTH-1:0] addr;
        logic [`AXI_STRB_WIDTH-1:0] strb;
        logic [`AXI_DATA_WIDTH-1:0] data;
    } wr_beat_t;

    // one FIFO word, decoded by is_req
    typedef union packed {
        wr_req_t  req;
        wr_beat_t beat;
    } wr_word_u;

    typedef struct packed {
        logic     is_req;
        wr_word_u word;
    } wr_entry_t;

    // ------------------------------------------------------------------------
    // AXI4 write channels
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [`AXI_ADDR_WIDTH-1:0] addr;
        logic [7:0]                 len;
        logic [2:0]                 size;
        logic [1:0]                 burst;
    } axi_aw_t;

    typedef struct packed {
        logic [`AXI_DATA_WIDTH-1:0] data;
        logic [`AXI_STRB_WIDTH-1:0] strb;
        logic                       last;
    } axi_w_t;

endpackage

// ==== hdl/axi_wr_consts.svh ====
// Memory-to-AXI4 write bridge constants
// bus widths, request FIFO depth and the AXI4 encodings used by the write path

`ifndef AXI_WR_CONSTS_SVH
`define AXI_WR_CONSTS_SVH

// ------------------------------------------------------------------------
// bus widths
// ------------------------------------------------------------------------
`define AXI_ADDR_WIDTH 32
`define AXI_DATA_WIDTH 32
`define AXI_STRB_WIDTH (`AXI_DATA_WIDTH / 8)
`define LOG_DATA_BYTES 2

// beat count of a request, byte length is 32 bits wide
`define BEAT_COUNT_WIDTH (32 - `LOG_DATA_BYTES)

// ------------------------------------------------------------------------
// buffering and AXI4 limits
// ------------------------------------------------------------------------
// 8 entries
`define WR_FIFO_DEPTH_LOG 3
`define AXI_MAX_BEATS 256

// AXI4 encodings
`define AXI_BURST_INCR 2'b01
`define AXI_RESP_OKAY 2'b00

`endif
